/* logic/klfe_macros.svh */
`ifndef KLFE_MACROS_SVH
`define KLFE_MACROS_SVH

//////////////////////////////////////////////////
// Word geometry of the PDP-10
//////////////////////////////////////////////////
`define KLFE_HALF_W 18
`define KLFE_WORD_W 36

// Diagnostic strobe timing in clocks
`define KLFE_STROBE_CYCLES 9
`define KLFE_IDLE_CYCLES 4
`define KLFE_RESET_STEPS 17

// Bootstrap image format
`define KLFE_FILE_BYTES 5
`define KLFE_IOWD_MIN 18'o400000

//////////////////////////////////////////////////
// APB register offsets
//////////////////////////////////////////////////
`define KLFE_REG_CTRL 8'h00
`define KLFE_REG_STATUS 8'h04
`define KLFE_REG_BYTE 8'h08
`define KLFE_REG_MIN 8'h0C
`define KLFE_REG_MAX 8'h10
`define KLFE_REG_START_LH 8'h14
`define KLFE_REG_START_RH 8'h18
`define KLFE_REG_COUNT 8'h1C

`endif

/* logic/klfe_pkg.sv */
`default_nettype none
`include "klfe_macros.svh"

package klfe_pkg;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  // Half word carries addresses and diagnostic data
  typedef logic [`KLFE_HALF_W-1:0] tHalf;
  // Full word, bit 35 is PDP-10 bit 0
  typedef logic [`KLFE_WORD_W-1:0] tWord;
  // One byte of the image file
  typedef logic [7:0] tFileByte;

  //////////////////////////////////////////////////
  // Diagnostic function codes, octal as on the EBUS
  //////////////////////////////////////////////////
  typedef enum logic [6:0] {
    diagfStopClock               = 7'o000,
    diagfStartClock              = 7'o001,
    diagfCondStep                = 7'o004,
    diagfClrReset                = 7'o006,
    diagfSetReset                = 7'o007,
    diagfClrRun                  = 7'o010,
    diagfClrBurstCtrRh           = 7'o042,
    diagfClrBurstCtrLh           = 7'o043,
    diagfClrClkSrcRate           = 7'o044,
    diagfSetEboxClkDisables      = 7'o045,
    diagfResetParRegs            = 7'o046,
    diagfClrMboxdisParchkErrstop = 7'o047,
    diagfEnableKl                = 7'o067,
    diagfInitChannels            = 7'o070,
    diagfWriteMbox               = 7'o071,
    diagfEbusLoad                = 7'o076,
    diagfIdle                    = 7'o177
  } tDiagFunc;

  // Master reset sequencer
  typedef enum logic [1:0] {seqIdle, seqStrobe, seqGap} tSeqState;

  // Bootstrap loader
  typedef enum logic [1:0] {loadHeader, loadData, loadDone} tLoadState;

endpackage

`default_nettype wire

/* logic/diagSequencer.sv */
`timescale 1ns/1ns
`default_nettype none
`include "klfe_macros.svh"

module diagSequencer import klfe_pkg::*; (
  input  wire      CLK,
  input  wire      rstN,
  input  wire      seqStart,
  output logic     seqBusy,
  output logic     seqDone,
  output tDiagFunc diagFunc,
  output tHalf     diagData,
  output logic     diagStrobe
);

  localparam int StepW = $clog2(`KLFE_RESET_STEPS);
  localparam int CntW = $clog2(`KLFE_STROBE_CYCLES);

  tSeqState         state;
  logic [StepW-1:0] stepIdx;
  logic [CntW-1:0]  cycleCnt;
  tDiagFunc         tableFunc;
  tHalf             tableData;

  //////////////////////////////////////////////////
  // Master reset table, as in the KLINIT $KLMR order
  //////////////////////////////////////////////////
  always_comb begin
    tableData = '0;
    case (stepIdx)
      0: tableFunc = diagfClrRun;
      1: begin
        // External clock, no divider
        tableFunc = diagfClrClkSrcRate;
        tableData = 18'o000010;
      end
      2: tableFunc = diagfStopClock;
      3: tableFunc = diagfSetReset;
      4: tableFunc = diagfResetParRegs;
      5: tableFunc = diagfClrMboxdisParchkErrstop;
      6: tableFunc = diagfClrBurstCtrRh;
      7: tableFunc = diagfClrBurstCtrLh;
      8: tableFunc = diagfSetEboxClkDisables;
      9: tableFunc = diagfStartClock;
      10: tableFunc = diagfInitChannels;
      11: tableFunc = diagfClrBurstCtrRh;
      // Second block, after MBOX sync in the original flow
      12: tableFunc = diagfCondStep;
      13: tableFunc = diagfClrReset;
      14: tableFunc = diagfEnableKl;
      15: tableFunc = diagfEbusLoad;
      16: begin
        // Memory reset through the MBOX
        tableFunc = diagfWriteMbox;
        tableData = 18'o000012;
      end
      default: tableFunc = diagfIdle;
    endcase
  end

  //////////////////////////////////////////////////
  // Strobe and gap FSM
  //////////////////////////////////////////////////
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      state    <= seqIdle;
      stepIdx  <= '0;
      cycleCnt <= '0;
      seqDone  <= 1'b0;
    end else begin
      case (state)
        seqIdle: begin
          // Start only from idle, a start while busy is dropped
          if (seqStart) begin
            state    <= seqStrobe;
            stepIdx  <= '0;
            cycleCnt <= '0;
            seqDone  <= 1'b0;
          end
        end
        seqStrobe: begin
          if (cycleCnt == CntW'(`KLFE_STROBE_CYCLES - 1)) begin
            state    <= seqGap;
            cycleCnt <= '0;
          end else begin
            cycleCnt <= cycleCnt + 1'b1;
          end
        end
        seqGap: begin
          if (cycleCnt == CntW'(`KLFE_IDLE_CYCLES - 1)) begin
            cycleCnt <= '0;
            // Last entry done
            if (stepIdx == StepW'(`KLFE_RESET_STEPS - 1)) begin
              state   <= seqIdle;
              seqDone <= 1'b1;
            end else begin
              state   <= seqStrobe;
              stepIdx <= stepIdx + 1'b1;
            end
          end else begin
            cycleCnt <= cycleCnt + 1'b1;
          end
        end
        default: state <= seqIdle;
      endcase
    end
  end

  // Bus outputs follow state, idle code and zero data outside strobe
  assign seqBusy    = (state != seqIdle);
  assign diagStrobe = (state == seqStrobe);
  assign diagFunc   = diagStrobe ? tableFunc : diagfIdle;
  assign diagData   = diagStrobe ? tableData : '0;

endmodule

`default_nettype wire

/* logic/bootWordPacker.sv */
`timescale 1ns/1ns
`default_nettype none
`include "klfe_macros.svh"

module bootWordPacker import klfe_pkg::*; (
  input  wire           CLK,
  input  wire           rstN,
  input  wire           loadClear,
  input  wire           byteValid,
  input  wire tFileByte fileByte,
  output logic          wordValid,
  output tWord          fileWord
);

  localparam int CntW = $clog2(`KLFE_FILE_BYTES);

  // Bytes of the current word taken so far
  logic [CntW-1:0] byteCnt;

  //////////////////////////////////////////////////
  // Byte shifter that moves the first byte to the top
  //////////////////////////////////////////////////
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      byteCnt   <= '0;
      wordValid <= 1'b0;
      fileWord  <= '0;
    end else begin
      wordValid <= 1'b0;
      if (loadClear) begin
        byteCnt <= '0;
      end else if (byteValid) begin
        if (byteCnt == CntW'(`KLFE_FILE_BYTES - 1)) begin
          // Only the upper nibble of the fifth byte belongs to the word
          fileWord  <= {fileWord[`KLFE_WORD_W-5:0], fileByte[7:4]};
          wordValid <= 1'b1;
          byteCnt   <= '0;
        end else begin
          fileWord <= {fileWord[`KLFE_WORD_W-9:0], fileByte};
          byteCnt  <= byteCnt + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* logic/bootImageLoader.sv */
`timescale 1ns/1ns
`default_nettype none
`include "klfe_macros.svh"

module bootImageLoader import klfe_pkg::*; (
  input  wire       CLK,
  input  wire       rstN,
  input  wire       loadClear,
  input  wire       wordValid,
  input  wire tWord fileWord,
  output logic      memWe,
  output tHalf      memAddr,
  output tWord      memData,
  output logic      loadDone,
  output tHalf      minAddr,
  output tHalf      maxAddr,
  output tWord      startWord,
  output tHalf      wordCount
);

  tLoadState state;
  tHalf      curAddr;
  tHalf      remaining;
  tHalf      leftHalf;
  tHalf      rightHalf;

  // LH holds the negative count of a header and RH the load address
  assign leftHalf  = fileWord[`KLFE_WORD_W-1:`KLFE_HALF_W];
  assign rightHalf = fileWord[`KLFE_HALF_W-1:0];

  //////////////////////////////////////////////////
  // IOWD parser and statistics
  //////////////////////////////////////////////////
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      state     <= loadHeader;
      memWe     <= 1'b0;
      curAddr   <= '0;
      remaining <= '0;
      minAddr   <= '1;
      maxAddr   <= '0;
      startWord <= '0;
      wordCount <= '0;
    end else begin
      memWe <= 1'b0;
      if (loadClear) begin
        state     <= loadHeader;
        minAddr   <= '1;
        maxAddr   <= '0;
        startWord <= '0;
        wordCount <= '0;
      end else if (wordValid) begin
        case (state)
          loadHeader: begin
            if (leftHalf >= `KLFE_IOWD_MIN) begin
              // Block length is 2^18 minus LH taken modulo 2^18
              remaining <= '0 - leftHalf;
              curAddr   <= rightHalf;
              state     <= loadData;
            end else begin
              // Anything else is the start instruction
              startWord <= fileWord;
              state     <= klfe_pkg::loadDone;
            end
          end
          loadData: begin
            memWe     <= 1'b1;
            curAddr   <= curAddr + 1'b1;
            wordCount <= wordCount + 1'b1;
            if (curAddr < minAddr) begin
              minAddr <= curAddr;
            end
            if (curAddr > maxAddr) begin
              maxAddr <= curAddr;
            end
            // Back to header after last word of block
            remaining <= remaining - 1'b1;
            if (remaining == tHalf'(1)) begin
              state <= loadHeader;
            end
          end
          // Words after the start word wait for a clear
          default: state <= klfe_pkg::loadDone;
        endcase
      end
    end
  end

  // Address and data for the memory write port
  always_ff @(posedge CLK) begin
    if (wordValid && state == loadData) begin
      memAddr <= curAddr;
      memData <= fileWord;
    end
  end

  assign loadDone = (state == klfe_pkg::loadDone);

endmodule

`default_nettype wire

/* logic/apbRegisterBlock.sv */
`timescale 1ns/1ns
`default_nettype none
`include "klfe_macros.svh"

module apbRegisterBlock import klfe_pkg::*; (
  input  wire         CLK,
  input  wire         rstN,
  input  wire         PSEL,
  input  wire         PENABLE,
  input  wire         PWRITE,
  input  wire  [7:0]  PADDR,
  input  wire  [31:0] PWDATA,
  output logic [31:0] PRDATA,
  output logic        seqStart,
  output logic        loadClear,
  output logic        byteValid,
  output tFileByte    fileByte,
  input  wire         seqBusy,
  input  wire         seqDone,
  input  wire         loadDone,
  input  wire tHalf   minAddr,
  input  wire tHalf   maxAddr,
  input  wire tWord   startWord,
  input  wire tHalf   wordCount
);

  localparam int PadW = 32 - `KLFE_HALF_W;

  logic wrEn;
  logic ctrlWr;
  logic byteWr;

  // Access phase of a write, no wait states
  assign wrEn   = PSEL && PENABLE && PWRITE;
  assign ctrlWr = wrEn && (PADDR == `KLFE_REG_CTRL);
  assign byteWr = wrEn && (PADDR == `KLFE_REG_BYTE);

  //////////////////////////////////////////////////
  // Command pulses, one clock each
  //////////////////////////////////////////////////
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      seqStart  <= 1'b0;
      loadClear <= 1'b0;
      byteValid <= 1'b0;
    end else begin
      // CTRL bit 0 starts master reset, bit 1 clears loader
      seqStart  <= ctrlWr && PWDATA[0];
      loadClear <= ctrlWr && PWDATA[1];
      byteValid <= byteWr;
    end
  end

  // Byte travels alongside byteValid
  always_ff @(posedge CLK) begin
    if (byteWr) begin
      fileByte <= PWDATA[7:0];
    end
  end

  //////////////////////////////////////////////////
  // Read mux
  //////////////////////////////////////////////////
  always_comb begin
    case (PADDR)
      `KLFE_REG_STATUS:   PRDATA = {29'b0, loadDone, seqDone, seqBusy};
      `KLFE_REG_MIN:      PRDATA = {{PadW{1'b0}}, minAddr};
      `KLFE_REG_MAX:      PRDATA = {{PadW{1'b0}}, maxAddr};
      // Start word split into halves
      `KLFE_REG_START_LH: PRDATA = {{PadW{1'b0}}, startWord[`KLFE_WORD_W-1:`KLFE_HALF_W]};
      `KLFE_REG_START_RH: PRDATA = {{PadW{1'b0}}, startWord[`KLFE_HALF_W-1:0]};
      `KLFE_REG_COUNT:    PRDATA = {{PadW{1'b0}}, wordCount};
      // CTRL and BYTE are write only
      default:            PRDATA = '0;
    endcase
  end

endmodule

`default_nettype wire

/* logic/klFrontEnd.sv */
`timescale 1ns/1ns
`default_nettype none
`include "klfe_macros.svh"

module klFrontEnd import klfe_pkg::*; (
  input  wire         CLK,
  input  wire         rstN,
  input  wire         PSEL,
  input  wire         PENABLE,
  input  wire         PWRITE,
  input  wire  [7:0]  PADDR,
  input  wire  [31:0] PWDATA,
  output logic [31:0] PRDATA,
  output tDiagFunc    diagFunc,
  output tHalf        diagData,
  output logic        diagStrobe,
  output logic        memWe,
  output tHalf        memAddr,
  output tWord        memData
);

  // Register block commands
  logic     seqStart;
  logic     loadClear;
  logic     byteValid;
  tFileByte fileByte;

  // Sequencer status
  logic seqBusy;
  logic seqDone;

  // Packer to loader
  logic wordValid;
  tWord fileWord;

  // Loader results
  logic loadDone;
  tHalf minAddr;
  tHalf maxAddr;
  tWord startWord;
  tHalf wordCount;

  //////////////////////////////////////////////////
  // Host interface
  //////////////////////////////////////////////////
  apbRegisterBlock regs (
    .CLK       (CLK),
    .rstN      (rstN),
    .PSEL      (PSEL),
    .PENABLE   (PENABLE),
    .PWRITE    (PWRITE),
    .PADDR     (PADDR),
    .PWDATA    (PWDATA),
    .PRDATA    (PRDATA),
    .seqStart  (seqStart),
    .loadClear (loadClear),
    .byteValid (byteValid),
    .fileByte  (fileByte),
    .seqBusy   (seqBusy),
    .seqDone   (seqDone),
    .loadDone  (loadDone),
    .minAddr   (minAddr),
    .maxAddr   (maxAddr),
    .startWord (startWord),
    .wordCount (wordCount)
  );

  // Master reset on the diagnostic bus
  diagSequencer seq (
    .CLK        (CLK),
    .rstN       (rstN),
    .seqStart   (seqStart),
    .seqBusy    (seqBusy),
    .seqDone    (seqDone),
    .diagFunc   (diagFunc),
    .diagData   (diagData),
    .diagStrobe (diagStrobe)
  );

  //////////////////////////////////////////////////
  // Bootstrap path
  //////////////////////////////////////////////////
  bootWordPacker packer (
    .CLK       (CLK),
    .rstN      (rstN),
    .loadClear (loadClear),
    .byteValid (byteValid),
    .fileByte  (fileByte),
    .wordValid (wordValid),
    .fileWord  (fileWord)
  );

  bootImageLoader loader (
    .CLK       (CLK),
    .rstN      (rstN),
    .loadClear (loadClear),
    .wordValid (wordValid),
    .fileWord  (fileWord),
    .memWe     (memWe),
    .memAddr   (memAddr),
    .memData   (memData),
    .loadDone  (loadDone),
    .minAddr   (minAddr),
    .maxAddr   (maxAddr),
    .startWord (startWord),
    .wordCount (wordCount)
  );

endmodule

`default_nettype wire

/* verification/klFrontEnd_props.sv */
`timescale 1ns/1ns
`default_nettype none
`include "klfe_macros.svh"

module klFrontEnd_props import klfe_pkg::*; (
  input wire           CLK,
  input wire           rstN,
  input wire           diagStrobe,
  input wire tDiagFunc diagFunc,
  input wire           memWe
);

  int highCnt;

  // Clocks the strobe has been high so far
  always_ff @(posedge CLK or negedge rstN) begin
    if (!rstN) begin
      highCnt <= 0;
    end else if (diagStrobe) begin
      highCnt <= highCnt + 1;
    end else begin
      highCnt <= 0;
    end
  end

  //////////////////////////////////////////////////
  // Diagnostic bus timing
  //////////////////////////////////////////////////
  strobeNotTooLong: assert property (@(posedge CLK) disable iff (!rstN)
    diagStrobe |-> highCnt < `KLFE_STROBE_CYCLES)
    else $error("Diagnostic strobe stayed high past its length");

  // Count seen at the falling edge is the full episode
  strobeFullLength: assert property (@(posedge CLK) disable iff (!rstN)
    $fell(diagStrobe) |-> highCnt == `KLFE_STROBE_CYCLES)
    else $error("Diagnostic strobe dropped early");

  idleCodeWhenLow: assert property (@(posedge CLK) disable iff (!rstN)
    !diagStrobe |-> diagFunc == diagfIdle)
    else $error("Function code not idle while strobe is low");

  // Memory port
  singleCycleWrite: assert property (@(posedge CLK) disable iff (!rstN)
    memWe |=> !memWe)
    else $error("memWe high for two clocks in a row");

endmodule

bind klFrontEnd klFrontEnd_props props (
  .CLK        (CLK),
  .rstN       (rstN),
  .diagStrobe (diagStrobe),
  .diagFunc   (diagFunc),
  .memWe      (memWe)
);

`default_nettype wire

/* verification/klFrontEndTb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "klfe_macros.svh"

module klFrontEndTb import klfe_pkg::*; ();

  localparam int OpWrite = 0;
  localparam int OpRead = 1;
  localparam int OpWait = 2;
  localparam int SeqClocks = `KLFE_RESET_STEPS * (`KLFE_STROBE_CYCLES + `KLFE_IDLE_CYCLES);
  // Setup, access and idle phase of one APB transfer
  localparam int ApbClocks = 3;
  localparam int ResetClocks = 3;

  logic        CLK;
  logic        rstN;
  logic        PSEL;
  logic        PENABLE;
  logic        PWRITE;
  logic [7:0]  PADDR;
  logic [31:0] PWDATA;
  logic [31:0] PRDATA;
  tDiagFunc    diagFunc;
  tHalf        diagData;
  logic        diagStrobe;
  logic        memWe;
  tHalf        memAddr;
  tWord        memData;

  // Stimulus table columns
  int          stepOp[$];
  logic [7:0]  stepAddr[$];
  logic [31:0] stepData[$];
  logic [31:0] stepExp[$];
  string       stepName[$];

  // Expected and observed memory writes
  tHalf expAddrQ[$];
  tWord expDataQ[$];
  tHalf gotAddrQ[$];
  tWord gotDataQ[$];

  // Observed strobe episodes and gaps
  tDiagFunc epFuncQ[$];
  tHalf     epDataQ[$];
  int       epLenQ[$];
  int       gapLenQ[$];
  tDiagFunc heldFunc;
  tHalf     heldData;
  logic     prevStrobe;
  int       highLen;
  int       lowLen;

  logic [31:0] lcgState = 32'he0c0;
  int          cycleCount = 0;
  int          timeoutLimit = 100000;

  // Master reset order from the KL10 front end
  tDiagFunc expFunc [`KLFE_RESET_STEPS] = '{
    diagfClrRun, diagfClrClkSrcRate, diagfStopClock, diagfSetReset,
    diagfResetParRegs, diagfClrMboxdisParchkErrstop, diagfClrBurstCtrRh,
    diagfClrBurstCtrLh, diagfSetEboxClkDisables, diagfStartClock,
    diagfInitChannels, diagfClrBurstCtrRh, diagfCondStep, diagfClrReset,
    diagfEnableKl, diagfEbusLoad, diagfWriteMbox
  };
  tHalf expData [`KLFE_RESET_STEPS];

  klFrontEnd UUT (
    .CLK        (CLK),
    .rstN       (rstN),
    .PSEL       (PSEL),
    .PENABLE    (PENABLE),
    .PWRITE     (PWRITE),
    .PADDR      (PADDR),
    .PWDATA     (PWDATA),
    .PRDATA     (PRDATA),
    .diagFunc   (diagFunc),
    .diagData   (diagData),
    .diagStrobe (diagStrobe),
    .memWe      (memWe),
    .memAddr    (memAddr),
    .memData    (memData)
  );

  always #2 CLK = ~CLK;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("sim failed");
      $fatal(1, "Stopping at the first mismatch");
    end
  endtask

  task automatic addStep(input int op, input logic [7:0] addr, input logic [31:0] data,
                         input logic [31:0] expected, input string name);
    stepOp.push_back(op);
    stepAddr.push_back(addr);
    stepData.push_back(data);
    stepExp.push_back(expected);
    stepName.push_back(name);
  endtask

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // 36-bit data word from two LCG draws
  task automatic makeDataWord(output tWord word);
    logic [31:0] upper;
    upper = lcgNext(lcgState);
    lcgState = lcgNext(upper);
    word = {upper[3:0], lcgState};
  endtask

  // Five byte writes, high byte first
  task automatic addWordBytes(input tWord word);
    int i;
    for (i = 0; i < `KLFE_FILE_BYTES - 1; i++) begin
      addStep(OpWrite, `KLFE_REG_BYTE, {24'b0, word[35 - 8 * i -: 8]}, 32'b0, "byte write");
    end
    // Low nibble rides in the top of the fifth byte
    addStep(OpWrite, `KLFE_REG_BYTE, {24'b0, word[3:0], 4'b0}, 32'b0, "byte write");
  endtask

  // IOWD header then random data words
  task automatic addBlock(input tHalf addr, input int count);
    tWord word;
    int   i;
    addWordBytes({tHalf'((1 << `KLFE_HALF_W) - count), addr});
    for (i = 0; i < count; i++) begin
      makeDataWord(word);
      addWordBytes(word);
      expAddrQ.push_back(addr + tHalf'(i));
      expDataQ.push_back(word);
    end
  endtask

  // One transfer, inputs change 1 ns after the edge
  task automatic apbAccess(input logic write, input logic [7:0] addr,
                           input logic [31:0] data, output logic [31:0] rdata);
    @(posedge CLK);
    #1;
    PSEL = 1'b1;
    PENABLE = 1'b0;
    PWRITE = write;
    PADDR = addr;
    PWDATA = data;
    @(posedge CLK);
    #1;
    PENABLE = 1'b1;
    rdata = PRDATA;
    @(posedge CLK);
    #1;
    PSEL = 1'b0;
    PENABLE = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Bus monitors, sampled mid cycle
  //////////////////////////////////////////////////
  always @(negedge CLK) begin
    if (!rstN) begin
      prevStrobe = 1'b0;
      highLen = 0;
      lowLen = 0;
    end else if (diagStrobe) begin
      if (!prevStrobe) begin
        // Gap is only counted between two episodes
        if (epFuncQ.size() > 0) begin
          gapLenQ.push_back(lowLen);
        end
        heldFunc = diagFunc;
        heldData = diagData;
        highLen = 0;
      end
      checkValue("function held under strobe", heldFunc, diagFunc);
      checkValue("data held under strobe", heldData, diagData);
      highLen++;
      prevStrobe = 1'b1;
    end else begin
      if (prevStrobe) begin
        epFuncQ.push_back(heldFunc);
        epDataQ.push_back(heldData);
        epLenQ.push_back(highLen);
        lowLen = 0;
      end
      checkValue("idle code without strobe", diagfIdle, diagFunc);
      checkValue("zero data without strobe", 0, diagData);
      lowLen++;
      prevStrobe = 1'b0;
    end
  end

  always @(negedge CLK) begin
    if (rstN && memWe) begin
      gotAddrQ.push_back(memAddr);
      gotDataQ.push_back(memData);
    end
  end

  // Run limit
  always @(posedge CLK) begin
    cycleCount++;
    if (cycleCount > timeoutLimit) begin
      $display("Timeout: the run did not finish within %0d clocks", timeoutLimit);
      $display("sim failed");
      $fatal(1, "Cycle limit reached");
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////
  initial begin
    int          i;
    logic [31:0] rdata;
    CLK = 1'b0;
    rstN = 1'b0;
    PSEL = 1'b0;
    PENABLE = 1'b0;
    PWRITE = 1'b0;
    PADDR = 8'h00;
    PWDATA = 32'h0;
    foreach (expData[k]) begin
      expData[k] = '0;
    end
    expData[1] = 18'o000010;
    expData[16] = 18'o000012;

    // Reset state and master reset, second start is ignored
    addStep(OpRead, `KLFE_REG_STATUS, 0, 32'h0, "status after reset");
    addStep(OpWrite, `KLFE_REG_CTRL, 32'h1, 0, "start master reset");
    addStep(OpWrite, `KLFE_REG_CTRL, 32'h1, 0, "start while busy");
    addStep(OpRead, `KLFE_REG_STATUS, 0, 32'h1, "status busy");
    addStep(OpWait, `KLFE_REG_STATUS, 1, 0, "wait sequence done");
    addStep(OpRead, `KLFE_REG_STATUS, 0, 32'h2, "status sequence done");

    // First image, two blocks then a JRST start word
    addBlock(18'o040000, 3);
    addBlock(18'o001000, 2);
    addWordBytes(36'o254000_001000);
    addStep(OpWait, `KLFE_REG_STATUS, 2, 0, "wait load done");
    addStep(OpRead, `KLFE_REG_STATUS, 0, 32'h6, "status load done");
    addStep(OpRead, `KLFE_REG_MIN, 0, 18'o001000, "min address");
    addStep(OpRead, `KLFE_REG_MAX, 0, 18'o040002, "max address");
    addStep(OpRead, `KLFE_REG_COUNT, 0, 5, "word count");
    addStep(OpRead, `KLFE_REG_START_LH, 0, 18'o254000, "start word left");
    addStep(OpRead, `KLFE_REG_START_RH, 0, 18'o001000, "start word right");

    // Clear, then a single block image
    addStep(OpWrite, `KLFE_REG_CTRL, 32'h2, 0, "clear loader");
    addStep(OpRead, `KLFE_REG_STATUS, 0, 32'h2, "status after clear");
    addStep(OpRead, `KLFE_REG_MIN, 0, 32'h3ffff, "min after clear");
    addStep(OpRead, `KLFE_REG_COUNT, 0, 0, "count after clear");
    addBlock(18'o002000, 2);
    addWordBytes(36'o254000_002000);
    addStep(OpWait, `KLFE_REG_STATUS, 2, 0, "wait second load");
    addStep(OpRead, `KLFE_REG_MIN, 0, 18'o002000, "second min address");
    addStep(OpRead, `KLFE_REG_MAX, 0, 18'o002001, "second max address");
    addStep(OpRead, `KLFE_REG_COUNT, 0, 2, "second word count");
    addStep(OpRead, `KLFE_REG_START_LH, 0, 18'o254000, "second start left");
    addStep(OpRead, `KLFE_REG_START_RH, 0, 18'o002000, "second start right");

    timeoutLimit = 2 * (SeqClocks + ApbClocks * stepOp.size() + ResetClocks);

    repeat (ResetClocks) @(posedge CLK);
    #1;
    rstN = 1'b1;
    checkValue("strobe after reset", 0, diagStrobe);
    checkValue("memWe after reset", 0, memWe);
    checkValue("function after reset", diagfIdle, diagFunc);

    for (i = 0; i < stepOp.size(); i++) begin
      case (stepOp[i])
        OpWrite: apbAccess(1'b1, stepAddr[i], stepData[i], rdata);
        OpRead: begin
          apbAccess(1'b0, stepAddr[i], 32'b0, rdata);
          checkValue(stepName[i], stepExp[i], rdata);
        end
        default: begin
          // Poll until the bit named in the data column is set
          apbAccess(1'b0, stepAddr[i], 32'b0, rdata);
          while (!rdata[stepData[i][4:0]]) begin
            apbAccess(1'b0, stepAddr[i], 32'b0, rdata);
          end
        end
      endcase
    end

    // Diagnostic bus against the master reset table
    checkValue("strobe episode count", `KLFE_RESET_STEPS, epFuncQ.size());
    for (i = 0; i < `KLFE_RESET_STEPS; i++) begin
      checkValue("episode function", expFunc[i], epFuncQ[i]);
      checkValue("episode data", expData[i], epDataQ[i]);
      checkValue("strobe length", `KLFE_STROBE_CYCLES, epLenQ[i]);
    end
    checkValue("gap count", `KLFE_RESET_STEPS - 1, gapLenQ.size());
    foreach (gapLenQ[k]) begin
      checkValue("gap length", `KLFE_IDLE_CYCLES, gapLenQ[k]);
    end

    // Memory writes in order
    checkValue("memory write count", expAddrQ.size(), gotAddrQ.size());
    foreach (expAddrQ[k]) begin
      checkValue("memory write address", expAddrQ[k], gotAddrQ[k]);
      checkValue("memory write data", expDataQ[k], gotDataQ[k]);
    end

    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+logic
logic/klfe_pkg.sv
logic/diagSequencer.sv
logic/bootWordPacker.sv
logic/bootImageLoader.sv
logic/apbRegisterBlock.sv
logic/klFrontEnd.sv
verification/klFrontEnd_props.sv
verification/klFrontEndTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the klFrontEnd testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module klFrontEndTb -o klFrontEndSim

# Keep the log of a failing run for the search below
./obj_dir/klFrontEndSim > sim.log 2>&1 || true
cat sim.log

# A run that never reached its end counts as a failure too
if grep -q "sim failed" sim.log || ! grep -q "sim passed" sim.log; then
  echo "run.sh: simulation FAILED"
  exit 1
fi
echo "run.sh: simulation finished cleanly"
